/* cache_defines.svh */
`ifndef CACHE_DEFINES_SVH
`define CACHE_DEFINES_SVH

// address split: tag | index | byte offset
`define CACHE_TAG_W     20
`define CACHE_INDEX_W   8
`define CACHE_OFFSET_W  4

// line and set geometry
`define CACHE_WORDS     4
`define CACHE_WAYS      2

// victim lfsr start value, must be nonzero
`define CACHE_LFSR_SEED 8'h01

`endif

/* cache_pkg.sv */
`default_nettype none
`include "cache_defines.svh"

package cache_pkg;

    typedef enum logic {
        op_read  = 1'b0,
        op_write = 1'b1
    } cache_op_e;

    // cpu request, also the lookup stage holding register
    typedef struct packed {
        cache_op_e                  op;
        logic [`CACHE_TAG_W-1:0]    tag;
        logic [`CACHE_INDEX_W-1:0]  index;
        logic [`CACHE_OFFSET_W-1:0] offset;
        logic [3:0]                 wstrb;
        logic [31:0]                wdata;
    } cache_req_t;

    typedef struct packed {
        cache_op_e   op;
        logic [31:0] rdata;
    } cache_resp_t;

    typedef logic [`CACHE_WORDS-1:0][31:0] line_t;

    // line aligned read address
    typedef logic [31:0] mem_rd_req_t;

    // one refill beat
    typedef struct packed {
        logic [31:0] data;
        logic        last;
    } mem_ret_t;

    typedef struct packed {
        logic [31:0] addr;
        line_t       line;
    } mem_wr_req_t;

    typedef struct packed {
        logic [`CACHE_TAG_W-1:0] tag;
        logic                    valid;
        logic                    dirty;
    } meta_t;

    typedef enum logic [2:0] {
        ms_idle,
        ms_writeback,
        ms_read_req,
        ms_refill,
        ms_install
    } miss_state_e;

    // byte lanes of new_w replace old_w where strb is set
    function automatic logic [31:0] merge_word(
        input logic [31:0] old_w,
        input logic [31:0] new_w,
        input logic [3:0]  strb
    );
        logic [31:0] res;
        res = old_w;
        for (int k = 0; k < 4; k++) begin
            if (strb[k]) begin
                res[k*8 +: 8] = new_w[k*8 +: 8];
            end
        end
        return res;
    endfunction

endpackage

`default_nettype wire

/* cache_meta_array.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cache_defines.svh"

module cache_meta_array
    import cache_pkg::*;
(
    input  wire logic                     clk,
    input  wire logic                     resetn,
    input  wire logic [`CACHE_INDEX_W-1:0] rd_index,
    output meta_t [`CACHE_WAYS-1:0]       rd_meta,
    input  wire logic [`CACHE_WAYS-1:0]   wr_en,
    input  wire logic [`CACHE_INDEX_W-1:0] wr_index,
    input  wire meta_t                    wr_meta
);

    logic [`CACHE_TAG_W-1:0] tag_mem [`CACHE_WAYS][1 << `CACHE_INDEX_W];
    // state bits live in flops so reset leaves every line invalid
    logic [`CACHE_WAYS-1:0][(1 << `CACHE_INDEX_W)-1:0] valid_q;
    logic [`CACHE_WAYS-1:0][(1 << `CACHE_INDEX_W)-1:0] dirty_q;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else begin
            for (int w = 0; w < `CACHE_WAYS; w++) begin
                if (wr_en[w]) begin
                    valid_q[w][wr_index] <= wr_meta.valid;
                    dirty_q[w][wr_index] <= wr_meta.dirty;
                end
            end
        end
    end

    // tag write and registered read, same set written this cycle wins
    always_ff @(posedge clk) begin
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            if (wr_en[w]) begin
                tag_mem[w][wr_index] <= wr_meta.tag;
            end
            if (wr_en[w] && wr_index == rd_index) begin
                rd_meta[w] <= wr_meta;
            end else begin
                rd_meta[w] <= meta_t'{tag: tag_mem[w][rd_index],
                                      valid: valid_q[w][rd_index],
                                      dirty: dirty_q[w][rd_index]};
            end
        end
    end

    // hit store and line install are never granted together
    one_way_write: assert property (@(posedge clk) disable iff (!resetn) !(&wr_en));

endmodule

`default_nettype wire

/* cache_data_array.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cache_defines.svh"

module cache_data_array
    import cache_pkg::*;
(
    input  wire logic                      clk,
    input  wire logic [`CACHE_INDEX_W-1:0] rd_index,
    output line_t [`CACHE_WAYS-1:0]        rd_line,
    input  wire logic                      wr_way,
    input  wire logic [`CACHE_INDEX_W-1:0] wr_index,
    input  wire logic [`CACHE_WORDS-1:0]   wr_bank_en,
    input  wire logic [3:0]                wr_strb,
    input  wire line_t                     wr_line,
    input  wire logic                      wr_en
);

    // one word bank per way and word position
    logic [31:0] mem [`CACHE_WAYS][`CACHE_WORDS][1 << `CACHE_INDEX_W];
    logic [`CACHE_WAYS-1:0][`CACHE_WORDS-1:0][3:0] byte_we;

    always_comb begin
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            for (int b = 0; b < `CACHE_WORDS; b++) begin
                for (int k = 0; k < 4; k++) begin
                    byte_we[w][b][k] = wr_en && (int'(wr_way) == w) && wr_bank_en[b]
                                       && wr_strb[k];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            for (int b = 0; b < `CACHE_WORDS; b++) begin
                for (int k = 0; k < 4; k++) begin
                    if (byte_we[w][b][k]) begin
                        mem[w][b][wr_index][k*8 +: 8] <= wr_line[b][k*8 +: 8];
                    end
                    // bypass per byte lane so a partial store merges with old data
                    if (byte_we[w][b][k] && wr_index == rd_index) begin
                        rd_line[w][b][k*8 +: 8] <= wr_line[b][k*8 +: 8];
                    end else begin
                        rd_line[w][b][k*8 +: 8] <= mem[w][b][rd_index][k*8 +: 8];
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

/* cache_lookup.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cache_defines.svh"

module cache_lookup
    import cache_pkg::*;
(
    input  wire logic                          clk,
    input  wire logic                          resetn,
    input  wire logic                          req_valid,
    input  wire cache_req_t                    req,
    output logic                               req_ready,
    output logic                               resp_valid,
    output cache_resp_t                        resp,
    input  wire logic                          resp_ready,
    output logic [`CACHE_INDEX_W-1:0]          arr_rd_index,
    input  wire meta_t [`CACHE_WAYS-1:0]       meta_rd,
    input  wire line_t [`CACHE_WAYS-1:0]       line_rd,
    output logic                               hit_wr_en,
    output logic                               hit_wr_way,
    output logic [`CACHE_INDEX_W-1:0]          hit_wr_index,
    output logic [$clog2(`CACHE_WORDS)-1:0]    hit_wr_bank,
    output logic [3:0]                         hit_wr_strb,
    output logic [31:0]                        hit_wr_word,
    output logic                               miss_start,
    output cache_req_t                         miss_req,
    output meta_t [`CACHE_WAYS-1:0]            miss_meta,
    output line_t [`CACHE_WAYS-1:0]            miss_line,
    input  wire logic                          miss_done,
    input  wire logic [31:0]                   miss_word
);

    logic                             s1_valid;
    cache_req_t                       s1_req;
    logic                             miss_pending;
    logic [`CACHE_WAYS-1:0]           way_hit;
    logic                             s1_hit;
    logic                             s1_way;
    logic [$clog2(`CACHE_WORDS)-1:0]  s1_bank;
    logic [31:0]                      s1_word;
    logic                             s1_go;
    logic                             s1_fire;
    logic                             miss_det;
    logic                             accept;

    // tag compare
    always_comb begin
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            way_hit[w] = meta_rd[w].valid && (meta_rd[w].tag == s1_req.tag);
        end
    end

    assign s1_hit  = |way_hit;
    assign s1_way  = way_hit[1];
    assign s1_bank = s1_req.offset[`CACHE_OFFSET_W-1:2];
    assign s1_word = (s1_req.op == op_write) ?
                     merge_word(line_rd[s1_way][s1_bank], s1_req.wdata, s1_req.wstrb) :
                     line_rd[s1_way][s1_bank];

    // response slot free now or at this edge
    assign s1_go    = !resp_valid || resp_ready;
    assign s1_fire  = s1_valid && s1_hit && !miss_pending && s1_go;
    assign miss_det = s1_valid && !s1_hit && !miss_pending && s1_go;

    assign req_ready = !miss_pending && s1_go && (!s1_valid || s1_hit);
    assign accept    = req_valid && req_ready;

    // when nothing new comes in, keep reading the held set so the
    // lookup sees stores and installs to it
    assign arr_rd_index = accept ? req.index : s1_req.index;

    assign hit_wr_en    = s1_fire && (s1_req.op == op_write);
    assign hit_wr_way   = s1_way;
    assign hit_wr_index = s1_req.index;
    assign hit_wr_bank  = s1_bank;
    assign hit_wr_strb  = s1_req.wstrb;
    assign hit_wr_word  = s1_req.wdata;

    assign miss_req  = s1_req;
    assign miss_meta = meta_rd;
    assign miss_line = line_rd;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            s1_valid     <= 1'b0;
            miss_pending <= 1'b0;
            miss_start   <= 1'b0;
            resp_valid   <= 1'b0;
        end else begin
            miss_start <= miss_det;
            if (accept) begin
                s1_valid <= 1'b1;
            end else if (s1_fire || miss_done) begin
                s1_valid <= 1'b0;
            end
            if (miss_det) begin
                miss_pending <= 1'b1;
            end else if (miss_done) begin
                miss_pending <= 1'b0;
            end
            if (s1_fire || miss_done) begin
                resp_valid <= 1'b1;
            end else if (resp_ready) begin
                resp_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            s1_req <= req;
        end
        // a miss only starts with the slot empty, so miss_done never collides
        if (s1_fire) begin
            resp <= cache_resp_t'{op: s1_req.op, rdata: s1_word};
        end else if (miss_done) begin
            resp <= cache_resp_t'{op: s1_req.op, rdata: miss_word};
        end
    end

    resp_hold: assert property (@(posedge clk) disable iff (!resetn)
        resp_valid && !resp_ready |=> resp_valid && $stable(resp));

endmodule

`default_nettype wire

/* cache_miss_unit.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cache_defines.svh"

module cache_miss_unit
    import cache_pkg::*;
(
    input  wire logic                      clk,
    input  wire logic                      resetn,
    input  wire logic                      miss_start,
    input  wire cache_req_t                miss_req,
    input  wire meta_t [`CACHE_WAYS-1:0]   miss_meta,
    input  wire line_t [`CACHE_WAYS-1:0]   miss_line,
    output logic                           miss_done,
    output logic [31:0]                    miss_word,
    output logic                           rd_valid,
    output mem_rd_req_t                    rd_req,
    input  wire logic                      rd_ready,
    input  wire logic                      ret_valid,
    input  wire mem_ret_t                  ret,
    output logic                           wr_valid,
    output mem_wr_req_t                    wr_req,
    input  wire logic                      wr_ready,
    output logic                           inst_data_en,
    output logic                           inst_way,
    output logic [`CACHE_INDEX_W-1:0]      inst_index,
    output line_t                          inst_line,
    output logic [`CACHE_WAYS-1:0]         inst_meta_en,
    output meta_t                          inst_meta
);

    miss_state_e                      state;
    logic [7:0]                       lfsr;
    cache_req_t                       req_q;
    logic                             vic_way;
    logic [$clog2(`CACHE_WORDS)-1:0]  beat_cnt;
    logic [$clog2(`CACHE_WORDS)-1:0]  word_sel;
    line_t                            fill;
    line_t                            fill_merged;

    assign word_sel = req_q.offset[`CACHE_OFFSET_W-1:2];

    // fold a pending store into the refilled line
    always_comb begin
        fill_merged = fill;
        if (req_q.op == op_write) begin
            fill_merged[word_sel] = merge_word(fill[word_sel], req_q.wdata, req_q.wstrb);
        end
    end

    assign rd_valid = (state == ms_read_req);
    assign rd_req   = {req_q.tag, req_q.index, {`CACHE_OFFSET_W{1'b0}}};
    assign wr_valid = (state == ms_writeback);

    assign inst_data_en = (state == ms_install);
    assign inst_way     = vic_way;
    assign inst_index   = req_q.index;
    assign inst_line    = fill_merged;
    assign inst_meta_en = {`CACHE_WAYS{inst_data_en}} & {vic_way, !vic_way};
    assign inst_meta    = meta_t'{tag: req_q.tag, valid: 1'b1, dirty: req_q.op == op_write};

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state     <= ms_idle;
            lfsr      <= `CACHE_LFSR_SEED;
            beat_cnt  <= '0;
            miss_done <= 1'b0;
        end else begin
            miss_done <= 1'b0;
            case (state)
                ms_idle: begin
                    // victim is whatever way lfsr bit 0 points at
                    if (miss_start) begin
                        if (miss_meta[lfsr[0]].valid && miss_meta[lfsr[0]].dirty) begin
                            state <= ms_writeback;
                        end else begin
                            state <= ms_read_req;
                        end
                    end
                end
                ms_writeback: begin
                    if (wr_ready) begin
                        state <= ms_read_req;
                    end
                end
                ms_read_req: begin
                    if (rd_ready) begin
                        state    <= ms_refill;
                        beat_cnt <= '0;
                    end
                end
                ms_refill: begin
                    if (ret_valid) begin
                        beat_cnt <= beat_cnt + 1'b1;
                        if (ret.last) begin
                            state <= ms_install;
                        end
                    end
                end
                ms_install: begin
                    state     <= ms_idle;
                    miss_done <= 1'b1;
                    lfsr      <= {lfsr[6:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]};
                end
                default: state <= ms_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == ms_idle && miss_start) begin
            req_q       <= miss_req;
            vic_way     <= lfsr[0];
            wr_req.addr <= {miss_meta[lfsr[0]].tag, miss_req.index, {`CACHE_OFFSET_W{1'b0}}};
            wr_req.line <= miss_line[lfsr[0]];
        end
        if (state == ms_refill && ret_valid) begin
            fill[beat_cnt] <= ret.data;
        end
        if (state == ms_install) begin
            miss_word <= fill_merged[word_sel];
        end
    end

    wr_hold: assert property (@(posedge clk) disable iff (!resetn)
        wr_valid && !wr_ready |=> wr_valid && $stable(wr_req));

    rd_hold: assert property (@(posedge clk) disable iff (!resetn)
        rd_valid && !rd_ready |=> rd_valid && $stable(rd_req));

    // beats only after an accepted read request
    ret_in_refill: assert property (@(posedge clk) disable iff (!resetn)
        ret_valid |-> state == ms_refill);

endmodule

`default_nettype wire

/* cache_top.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cache_defines.svh"

module cache_top
    import cache_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        resetn,
    input  wire logic        req_valid,
    input  wire cache_req_t  req,
    output logic             req_ready,
    output logic             resp_valid,
    output cache_resp_t      resp,
    input  wire logic        resp_ready,
    output logic             rd_valid,
    output mem_rd_req_t      rd_req,
    input  wire logic        rd_ready,
    input  wire logic        ret_valid,
    input  wire mem_ret_t    ret,
    output logic             wr_valid,
    output mem_wr_req_t      wr_req,
    input  wire logic        wr_ready
);

    logic [`CACHE_INDEX_W-1:0]        arr_rd_index;
    meta_t [`CACHE_WAYS-1:0]          meta_rd;
    meta_t [`CACHE_WAYS-1:0]          miss_meta;
    line_t [`CACHE_WAYS-1:0]          line_rd;
    line_t [`CACHE_WAYS-1:0]          miss_line;
    logic                             hit_wr_en;
    logic                             hit_wr_way;
    logic [`CACHE_INDEX_W-1:0]        hit_wr_index;
    logic [$clog2(`CACHE_WORDS)-1:0]  hit_wr_bank;
    logic [3:0]                       hit_wr_strb;
    logic [31:0]                      hit_wr_word;
    logic                             miss_start;
    logic                             miss_done;
    cache_req_t                       miss_req;
    logic [31:0]                      miss_word;
    logic                             inst_data_en;
    logic                             inst_way;
    logic [`CACHE_INDEX_W-1:0]        inst_index;
    line_t                            inst_line;
    logic [`CACHE_WAYS-1:0]           inst_meta_en;
    meta_t                            inst_meta;
    logic [`CACHE_INDEX_W-1:0]        wr_index;
    logic                             data_wr_way;
    logic [`CACHE_WORDS-1:0]          data_bank_en;
    logic [3:0]                       data_strb;
    line_t                            data_wr_line;
    logic [`CACHE_WAYS-1:0]           meta_wr_en;
    meta_t                            meta_wr;

    // write ports go to the miss unit during install, else to hit stores
    assign wr_index     = inst_data_en ? inst_index : hit_wr_index;
    assign data_wr_way  = inst_data_en ? inst_way : hit_wr_way;
    assign data_bank_en = inst_data_en ? {`CACHE_WORDS{1'b1}} :
                          {{(`CACHE_WORDS-1){1'b0}}, 1'b1} << hit_wr_bank;
    assign data_strb    = inst_data_en ? 4'hf : hit_wr_strb;
    assign data_wr_line = inst_data_en ? inst_line : {`CACHE_WORDS{hit_wr_word}};
    // a store hit marks the line dirty, its tag is the held request tag
    assign meta_wr_en   = inst_data_en ? inst_meta_en :
                          {`CACHE_WAYS{hit_wr_en}} & {hit_wr_way, !hit_wr_way};
    assign meta_wr      = inst_data_en ? inst_meta :
                          meta_t'{tag: miss_req.tag, valid: 1'b1, dirty: 1'b1};

    cache_lookup i_lookup (
        .clk, .resetn,
        .req_valid, .req, .req_ready,
        .resp_valid, .resp, .resp_ready,
        .arr_rd_index, .meta_rd, .line_rd,
        .hit_wr_en, .hit_wr_way, .hit_wr_index, .hit_wr_bank, .hit_wr_strb, .hit_wr_word,
        .miss_start, .miss_req, .miss_meta, .miss_line,
        .miss_done, .miss_word
    );

    cache_miss_unit i_miss_unit (
        .clk, .resetn,
        .miss_start, .miss_req, .miss_meta, .miss_line,
        .miss_done, .miss_word,
        .rd_valid, .rd_req, .rd_ready,
        .ret_valid, .ret,
        .wr_valid, .wr_req, .wr_ready,
        .inst_data_en, .inst_way, .inst_index, .inst_line,
        .inst_meta_en, .inst_meta
    );

    cache_meta_array i_meta_array (
        .clk, .resetn,
        .rd_index (arr_rd_index),
        .rd_meta  (meta_rd),
        .wr_en    (meta_wr_en),
        .wr_index (wr_index),
        .wr_meta  (meta_wr)
    );

    cache_data_array i_data_array (
        .clk,
        .rd_index   (arr_rd_index),
        .rd_line    (line_rd),
        .wr_way     (data_wr_way),
        .wr_index   (wr_index),
        .wr_bank_en (data_bank_en),
        .wr_strb    (data_strb),
        .wr_line    (data_wr_line),
        .wr_en      (inst_data_en | hit_wr_en)
    );

endmodule

`default_nettype wire

/* tb_clk_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
    output logic clk,
    output logic resetn
);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // reset held low for four rising edges
    initial begin
        resetn = 1'b0;
        repeat (4) @(posedge clk);
        resetn <= 1'b1;
    end

endmodule

`default_nettype wire

/* tb_cache.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_cache
    import cache_pkg::*;
();

    typedef struct {
        cache_op_e   op;
        logic [31:0] addr;
        logic [3:0]  wstrb;
        logic [31:0] wdata;
        bit          hit;
        bit          hold;
    } row_t;

    typedef struct {
        cache_resp_t resp;
        bit          hit;
        int          acc_cyc;
    } exp_t;

    logic        clk;
    logic        resetn;
    logic        req_valid;
    cache_req_t  req;
    logic        req_ready;
    logic        resp_valid;
    cache_resp_t resp;
    logic        resp_ready;
    logic        rd_valid;
    mem_rd_req_t rd_req;
    logic        rd_ready;
    logic        ret_valid;
    mem_ret_t    ret;
    logic        wr_valid;
    mem_wr_req_t wr_req;
    logic        wr_ready;
    logic        cur_hit;
    logic        cur_hold;

    row_t        tbl[$];
    exp_t        exp_q[$];
    line_t       backing [logic [31:0]];
    logic [31:0] shadow [logic [31:0]];
    bit          dirty_lines [logic [31:0]];
    int          pending;
    int          limit;

    tb_clk_gen i_clk_gen (.clk, .resetn);

    cache_top i_dut (
        .clk, .resetn,
        .req_valid, .req, .req_ready,
        .resp_valid, .resp, .resp_ready,
        .rd_valid, .rd_req, .rd_ready,
        .ret_valid, .ret,
        .wr_valid, .wr_req, .wr_ready
    );

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // contents of memory that was never written
    function automatic logic [31:0] init_word(input logic [31:0] a);
        return ({a[31:2], 2'b00} * 32'h9e3779b1) ^ {a[15:0], a[31:16]};
    endfunction

    function automatic logic [31:0] shadow_word(input logic [31:0] a);
        logic [31:0] wa;
        wa = {a[31:2], 2'b00};
        return shadow.exists(wa) ? shadow[wa] : init_word(wa);
    endfunction

    function automatic line_t shadow_line(input logic [31:0] la);
        line_t l;
        for (int w = 0; w < 4; w++) begin
            l[w] = shadow_word(la + 32'(w * 4));
        end
        return l;
    endfunction

    function automatic logic [31:0] mem_word(input logic [31:0] la, input int w);
        return backing.exists(la) ? backing[la][w] : init_word(la + 32'(w * 4));
    endfunction

    task automatic fail_now();
        $display("Test failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_resp(input string name, input cache_resp_t got, input cache_resp_t exp);
        if (got !== exp) begin
            $display("ERR %0t %s got=%h exp=%h", $time, name, got, exp);
            fail_now();
        end
    endtask

    task automatic check_wb(input mem_wr_req_t got, input mem_wr_req_t exp);
        if (got !== exp) begin
            $display("ERR %0t wr_req got=%h exp=%h", $time, got, exp);
            fail_now();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERR %0t %s got=%b exp=%b", $time, name, got, exp);
            fail_now();
        end
    endtask

    task automatic add_row(input cache_op_e op, input logic [31:0] addr, input logic [3:0] strb,
                           input logic [31:0] data, input bit hit);
        tbl.push_back('{op: op, addr: addr, wstrb: strb, wdata: data, hit: hit, hold: 1'b0});
    endtask

    task automatic build_table();
        logic [31:0] r;
        r = 32'hafcb;
        // read miss then hits on the same line
        add_row(op_read,  32'h0000_1100, 4'h0, 32'h0, 1'b0);
        add_row(op_read,  32'h0000_1104, 4'h0, 32'h0, 1'b1);
        add_row(op_read,  32'h0000_1100, 4'h0, 32'h0, 1'b1);
        // partial stores to resident and absent lines
        add_row(op_write, 32'h0000_1108, 4'h3, 32'hdead_beef, 1'b0);
        add_row(op_read,  32'h0000_1108, 4'h0, 32'h0, 1'b1);
        add_row(op_write, 32'h0000_2208, 4'h4, 32'h1234_5678, 1'b0);
        add_row(op_read,  32'h0000_2208, 4'h0, 32'h0, 1'b1);
        add_row(op_write, 32'h0000_2208, 4'h9, 32'hcafe_f00d, 1'b0);
        add_row(op_read,  32'h0000_2208, 4'h0, 32'h0, 1'b0);
        // four tags on set 0x30 force evictions
        for (int t = 1; t <= 4; t++) begin
            add_row(op_write, {20'(t), 12'h300} + 32'((t - 1) * 4), 4'hf,
                    32'h1111_0000 * t, 1'b0);
        end
        for (int t = 1; t <= 4; t++) begin
            add_row(op_read, {20'(t), 12'h300} + 32'((t - 1) * 4), 4'h0, 32'h0, 1'b0);
            add_row(op_write, {20'(t), 12'h30c}, 4'h2, 32'h00ab_0000 + t, 1'b0);
        end
        // back to back reads of one resident line
        for (int w = 0; w < 4; w++) begin
            add_row(op_read, 32'h0000_1100 + 32'(w * 4), 4'h0, 32'h0, 1'b0);
        end
        // first response held so the next hits queue behind it
        tbl[tbl.size() - 4].hold = 1'b1;
        // random traffic over a few sets and tags
        for (int i = 0; i < 16; i++) begin
            r = lcg_step(r);
            add_row(r[20] ? op_write : op_read,
                    {18'h5, r[17:16], 4'h4, r[19:18], 2'b00, r[22:21], 2'b00},
                    (r[26:23] == 4'h0) ? 4'h1 : r[26:23], lcg_step(r), 1'b0);
        end
    endtask

    // response checks, ready stalls and the run limit
    always @(posedge clk) begin : monitor
        static int          cyc = 0;
        static int          stall_cnt = 0;
        static logic [31:0] rng = 32'hafcb ^ 32'h1111;
        static bit          held_v = 1'b0;
        static cache_resp_t held_r;
        exp_t               e;
        logic [31:0]        a;
        logic [31:0]        w;
        bit                 hit_q;
        cyc++;
        if (cyc > limit) begin
            $display("timeout: run passed %0d cycles with %0d responses outstanding",
                     limit, exp_q.size());
            fail_now();
        end
        if (!resetn) begin
            resp_ready <= 1'b0;
            held_v = 1'b0;
        end else begin
            if (held_v) begin
                check_flag("resp_valid", resp_valid, 1'b1);
                check_resp("resp", resp, held_r);
            end
            if (resp_valid && !resp_ready) begin
                check_flag("req_ready", req_ready, 1'b0);
            end
            held_v = resp_valid && !resp_ready;
            held_r = resp;
            if (resp_valid && resp_ready) begin
                if (exp_q.size() == 0) begin
                    $display("a response came with no request outstanding");
                    fail_now();
                end
                e = exp_q.pop_front();
                check_resp("resp", resp, e.resp);
                if (e.hit && cyc != e.acc_cyc + 2) begin
                    $display("ERR %0t resp latency got=%0d exp=1", $time, cyc - e.acc_cyc - 1);
                    fail_now();
                end
            end
            if (req_valid && req_ready) begin
                a = {req.tag, req.index, req.offset[3:2], 2'b00};
                w = shadow_word(a);
                if (req.op == op_write) begin
                    for (int k = 0; k < 4; k++) begin
                        if (req.wstrb[k]) begin
                            w[k*8 +: 8] = req.wdata[k*8 +: 8];
                        end
                    end
                    shadow[a] = w;
                    dirty_lines[{a[31:4], 4'h0}] = 1'b1;
                end
                if (cur_hold) begin
                    stall_cnt = 6;
                end
                exp_q.push_back('{resp: '{op: req.op, rdata: w}, hit: cur_hit, acc_cyc: cyc});
            end
            pending <= exp_q.size();
            hit_q = 1'b0;
            foreach (exp_q[k]) begin
                if (exp_q[k].hit) begin
                    hit_q = 1'b1;
                end
            end
            rng = lcg_step(rng);
            if (stall_cnt > 0) begin
                stall_cnt--;
            end else if (rng[15:13] == 3'd0) begin
                stall_cnt = 2 + rng[18:16] % 5;
            end
            resp_ready <= hit_q || stall_cnt == 0;
        end
    end

    // memory model serving write-backs and refills with random delays
    always @(posedge clk) begin : memory
        static logic [31:0] rng = 32'hafcb ^ 32'h2222;
        static bit          busy = 1'b0;
        static int          beat = 0;
        static logic [31:0] fetch = '0;
        rng = lcg_step(rng);
        if (!resetn) begin
            rd_ready  <= 1'b0;
            wr_ready  <= 1'b0;
            ret_valid <= 1'b0;
            busy = 1'b0;
        end else begin
            if (wr_valid && wr_ready) begin
                if (!dirty_lines.exists(wr_req.addr)) begin
                    $display("clean line at %h was written back", wr_req.addr);
                    fail_now();
                end
                check_wb(wr_req, '{addr: wr_req.addr, line: shadow_line(wr_req.addr)});
                dirty_lines.delete(wr_req.addr);
                backing[wr_req.addr] = wr_req.line;
            end
            if (rd_valid && rd_ready) begin
                fetch = rd_req;
                beat = 0;
                busy = 1'b1;
            end
            if (busy && rng[12:11] != 2'd0) begin
                ret_valid <= 1'b1;
                ret <= '{data: mem_word(fetch, beat), last: beat == 3};
                beat++;
                busy = beat < 4;
            end else begin
                ret_valid <= 1'b0;
            end
            rd_ready <= rng[4:3] != 2'd0;
            wr_ready <= rng[7:6] != 2'd0;
        end
    end

    initial begin
        req_valid  <= 1'b0;
        req        <= '0;
        cur_hit    <= 1'b0;
        cur_hold   <= 1'b0;
        resp_ready <= 1'b0;
        rd_ready   <= 1'b0;
        wr_ready   <= 1'b0;
        ret_valid  <= 1'b0;
        ret        <= '0;
        build_table();
        limit = tbl.size() * 60 + 4;
        @(posedge clk);
        while (!resetn) @(posedge clk);
        check_flag("req_ready", req_ready, 1'b1);
        check_flag("resp_valid", resp_valid, 1'b0);
        check_flag("rd_valid", rd_valid, 1'b0);
        check_flag("wr_valid", wr_valid, 1'b0);
        foreach (tbl[i]) begin
            if (tbl[i].hit) begin
                // drain so the hit sees an idle pipeline
                req_valid <= 1'b0;
                @(posedge clk);
                while (pending != 0) @(posedge clk);
            end
            req_valid <= 1'b1;
            cur_hit   <= tbl[i].hit;
            cur_hold  <= tbl[i].hold;
            req <= '{op: tbl[i].op, tag: tbl[i].addr[31:12], index: tbl[i].addr[11:4],
                     offset: tbl[i].addr[3:0], wstrb: tbl[i].wstrb, wdata: tbl[i].wdata};
            @(posedge clk);
            while (!req_ready) @(posedge clk);
        end
        req_valid <= 1'b0;
        @(posedge clk);
        while (pending != 0) @(posedge clk);
        repeat (2) @(posedge clk);
        if (exp_q.size() == 0) begin
            $display("Test completed successfully");
            $finish;
        end else begin
            $display("%0d responses never arrived", exp_q.size());
            fail_now();
        end
    end

endmodule

`default_nettype wire

/* tb.f */
+incdir+.
cache_pkg.sv
cache_meta_array.sv
cache_data_array.sv
cache_lookup.sv
cache_miss_unit.sv
cache_top.sv
tb_clk_gen.sv
tb_cache.sv

/* Bender.yml */
package:
  name: wb_cache

export_include_dirs:
  - .

sources:
  - cache_pkg.sv
  - cache_meta_array.sv
  - cache_data_array.sv
  - cache_lookup.sv
  - cache_miss_unit.sv
  - cache_top.sv
  - target: test
    files:
      - tb_clk_gen.sv
      - tb_cache.sv
